// File: common/csrTypes.sv
/*
 * CSR address map, register layouts and operation codes for the
 * machine-mode CSR subsystem. Referenced by scoped names from the RTL.
 */
package csrTypes;

    localparam int dataWidth = 32;
    localparam int csrNumWidth = 12;

    // Machine-mode CSR numbers
    localparam logic [csrNumWidth-1:0] csrMstatus = 12'h300;
    localparam logic [csrNumWidth-1:0] csrMie = 12'h304;
    localparam logic [csrNumWidth-1:0] csrMtvec = 12'h305;
    localparam logic [csrNumWidth-1:0] csrMscratch = 12'h340;
    localparam logic [csrNumWidth-1:0] csrMepc = 12'h341;
    localparam logic [csrNumWidth-1:0] csrMcause = 12'h342;
    localparam logic [csrNumWidth-1:0] csrMtval = 12'h343;
    localparam logic [csrNumWidth-1:0] csrMip = 12'h344;
    localparam logic [csrNumWidth-1:0] csrMcycle = 12'hB00;
    localparam logic [csrNumWidth-1:0] csrMinstret = 12'hB02;
    localparam logic [csrNumWidth-1:0] csrMhpmcounter3 = 12'hB03; // Load miss
    localparam logic [csrNumWidth-1:0] csrMhpmcounter4 = 12'hB04; // Store miss
    localparam logic [csrNumWidth-1:0] csrMhpmcounter5 = 12'hB05; // Branch mispredict

    // Low bits under the mtvec base, direct mode only
    localparam logic [1:0] mtvecAlign = 2'b00;

    typedef enum logic [1:0] {
        csrOpNone,
        csrOpWrite,
        csrOpSet,
        csrOpClear
    } CsrOp;

    typedef struct packed {
        logic [31:8] rsvdHigh;
        logic mpie;           // Bit 7
        logic [6:4] rsvdMid;
        logic mie;            // Bit 3
        logic [2:0] rsvdLow;
    } Mstatus;

    // Common layout of the pending and enable registers
    typedef struct packed {
        logic [31:12] rsvdHigh;
        logic meip;           // Bit 11
        logic [10:8] rsvdMid;
        logic mtip;           // Bit 7
        logic [6:0] rsvdLow;
    } IrqBits;

    typedef IrqBits Mip;
    typedef IrqBits Mie;

    typedef struct packed {
        logic isInterrupt;
        logic [dataWidth-2:0] code;
    } Mcause;

    typedef struct packed {
        logic [dataWidth-3:0] base;
        logic [1:0] mode;     // Stored, always treated as direct
    } Mtvec;

    typedef struct packed {
        Mstatus mstatus;
        Mie mie;
        Mip mip;
        Mcause mcause;
        Mtvec mtvec;
        logic [dataWidth-1:0] mtval;
        logic [dataWidth-1:0] mepc;
        logic [dataWidth-1:0] mscratch;
        logic [dataWidth-1:0] mcycle;
        logic [dataWidth-1:0] minstret;
    } CsrFile;

endpackage

// File: common/pipeTypes.sv
/*
 * Pipeline payloads between the commit slot, the commit stage and the
 * CSR stage, plus trap causes and interrupt codes.
 */
package pipeTypes;

    typedef enum logic [3:0] {
        causeNone,
        causeEcall,
        causeEbreak,
        causeMret,
        causeLoadMisaligned,
        causeStoreMisaligned,
        causeIllegalInsn
    } TrapCause;

    typedef logic [30:0] IrqCode;

    localparam IrqCode irqTimer = 31'd7;
    localparam IrqCode irqExternal = 31'd11;

    // Exception code written to mcause on trap entry
    function automatic logic [30:0] causeCode(TrapCause cause);
        case (cause)
            causeEcall: return 31'd11;
            causeEbreak: return 31'd3;
            causeLoadMisaligned: return 31'd4;
            causeStoreMisaligned: return 31'd6;
            causeIllegalInsn: return 31'd2;
            default: return 31'd0;
        endcase
    endfunction

    typedef struct packed {
        csrTypes::CsrOp csrOp;
        logic [csrTypes::csrNumWidth-1:0] csrNum;
        logic [csrTypes::dataWidth-1:0] writeData;
        TrapCause trap;       // causeMret marks an MRET
        logic [csrTypes::dataWidth-1:0] trapPc;
        logic [csrTypes::dataWidth-1:0] trapAddr;
        logic [1:0] retireCount;
    } CommitSlot;

    typedef enum logic [2:0] {
        actIdle,
        actCsrAccess,
        actTrap,
        actMret,
        actInterrupt
    } ActionKind;

    typedef struct packed {
        ActionKind kind;
        csrTypes::CsrOp csrOp;
        logic [csrTypes::csrNumWidth-1:0] csrNum;
        logic [csrTypes::dataWidth-1:0] writeData;
        TrapCause trap;
        logic [csrTypes::dataWidth-1:0] trapPc;
        logic [csrTypes::dataWidth-1:0] trapAddr;
        IrqCode irqCode;
        logic [1:0] retireCount;
    } CsrAction;

    typedef struct packed {
        logic valid;
        logic [csrTypes::dataWidth-1:0] target;
    } Redirect;

    typedef struct packed {
        logic loadMiss;
        logic storeMiss;
        logic branchMiss;
    } PerfEvents;

endpackage

// File: source/commitStage.sv
/*
 * First pipeline stage. Picks one action per cycle from the commit slot
 * and the pending interrupt, then registers it for the CSR stage.
 */
`timescale 1ns/1ps

module commitStage (
    input logic clk,
    input logic reset,
    input pipeTypes::CommitSlot slot,
    input logic irqPending,
    input pipeTypes::IrqCode irqCode,
    output pipeTypes::CsrAction action
);

    pipeTypes::CsrAction nextAction;
    logic irqTaken;
    logic isTrap;
    logic isMret;
    logic isAccess;

    // MIE is only cleared at the end of the entry cycle, so a second
    // interrupt must not be taken right behind a trap or interrupt
    assign irqTaken = irqPending
                      && action.kind != pipeTypes::actInterrupt
                      && action.kind != pipeTypes::actTrap;

    assign isMret = slot.trap == pipeTypes::causeMret;
    assign isTrap = slot.trap != pipeTypes::causeNone && !isMret;
    assign isAccess = slot.csrOp != csrTypes::csrOpNone;

    always_comb begin
        nextAction.csrOp = slot.csrOp;
        nextAction.csrNum = slot.csrNum;
        nextAction.writeData = slot.writeData;
        nextAction.trap = slot.trap;
        nextAction.trapPc = slot.trapPc;  // Also the return PC of an interrupt
        nextAction.trapAddr = slot.trapAddr;
        nextAction.irqCode = irqCode;
        nextAction.retireCount = slot.retireCount; // Passes even under an interrupt

        // Interrupt, trap, MRET, access
        if (irqTaken) begin
            nextAction.kind = pipeTypes::actInterrupt;
        end else if (isTrap) begin
            nextAction.kind = pipeTypes::actTrap;
        end else if (isMret) begin
            nextAction.kind = pipeTypes::actMret;
        end else if (isAccess) begin
            nextAction.kind = pipeTypes::actCsrAccess;
        end else begin
            nextAction.kind = pipeTypes::actIdle;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            action <= '0;  // Kind idle
        end else begin
            action <= nextAction;
        end
    end

    // Decode never pairs a CSR operation with a trap or MRET
    slotExclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(slot.trap != pipeTypes::causeNone && slot.csrOp != csrTypes::csrOpNone)
    ) else $error("Commit slot carries both a trap and a CSR operation");

endmodule

// File: source/interruptControl.sv
/*
 * Samples the timer and external interrupt lines into mip and decides
 * whether an enabled interrupt is pending, external before timer.
 */
`timescale 1ns/1ps

module interruptControl (
    input logic clk,
    input logic reset,
    input logic timerIrq,
    input logic extIrq,
    input logic mstatusMie,
    input csrTypes::Mie mieBits,
    output csrTypes::Mip mipBits,
    output logic irqPending,
    output pipeTypes::IrqCode irqCode
);

    csrTypes::Mip nextMip;
    logic extHit;
    logic timerHit;

    always_comb begin
        nextMip = '0;
        nextMip.mtip = timerIrq;
        nextMip.meip = extIrq;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mipBits <= '0;
        end else begin
            mipBits <= nextMip;  // Visible one cycle after the request
        end
    end

    assign extHit = mipBits.meip && mieBits.meip;
    assign timerHit = mipBits.mtip && mieBits.mtip;

    // Global enable gates both sources
    assign irqPending = mstatusMie && (extHit || timerHit);
    assign irqCode = extHit ? pipeTypes::irqExternal : pipeTypes::irqTimer;

endmodule

// File: csrUnit/perfCounters.sv
/*
 * Hardware event counters behind mhpmcounter3 to mhpmcounter5.
 * Each counter wraps and counts one on every cycle its strobe is high.
 */
`timescale 1ns/1ps

module perfCounters (
    input logic clk,
    input logic reset,
    input pipeTypes::PerfEvents events,
    output logic [csrTypes::dataWidth-1:0] loadMissCount,
    output logic [csrTypes::dataWidth-1:0] storeMissCount,
    output logic [csrTypes::dataWidth-1:0] branchMissCount
);

    logic [2:0] strobe;
    logic [2:0][csrTypes::dataWidth-1:0] count;

    // Index order matches mhpmcounter3..5
    assign strobe = {events.branchMiss, events.storeMiss, events.loadMiss};

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (strobe[i]) begin
                    count[i] <= count[i] + 1'b1;
                end
            end
        end
    end

    assign loadMissCount = count[0];
    assign storeMissCount = count[1];
    assign branchMissCount = count[2];

endmodule

// File: csrUnit/csrUnit.sv
/*
 * Second pipeline stage. Holds the machine-mode CSRs, reads and updates
 * them for the registered action and produces the redirect target.
 * Results are combinational in the cycle after the slot, state updates at its end.
 */
`timescale 1ns/1ps

module csrUnit (
    input logic clk,
    input logic reset,
    input pipeTypes::CsrAction action,
    input csrTypes::Mip mipBits,
    input logic [csrTypes::dataWidth-1:0] loadMissCount,
    input logic [csrTypes::dataWidth-1:0] storeMissCount,
    input logic [csrTypes::dataWidth-1:0] branchMissCount,
    output logic [csrTypes::dataWidth-1:0] readData,
    output pipeTypes::Redirect redirect,
    output csrTypes::CsrFile csrState
);

    csrTypes::CsrFile csrReg;
    csrTypes::CsrFile csrView;
    csrTypes::CsrFile csrNext;
    logic [csrTypes::dataWidth-1:0] oldValue;
    logic [csrTypes::dataWidth-1:0] newValue;
    logic doWrite;

    always_comb begin
        csrView = csrReg;
        csrView.mip = mipBits;  // Live request bits from interruptControl
    end

    // Read mux, old value of the addressed CSR
    always_comb begin
        case (action.csrNum)
            csrTypes::csrMstatus: oldValue = csrView.mstatus;
            csrTypes::csrMie: oldValue = csrView.mie;
            csrTypes::csrMip: oldValue = csrView.mip;
            csrTypes::csrMtvec: oldValue = csrView.mtvec;
            csrTypes::csrMscratch: oldValue = csrView.mscratch;
            csrTypes::csrMepc: oldValue = csrView.mepc;
            csrTypes::csrMcause: oldValue = csrView.mcause;
            csrTypes::csrMtval: oldValue = csrView.mtval;
            csrTypes::csrMcycle: oldValue = csrView.mcycle;
            csrTypes::csrMinstret: oldValue = csrView.minstret;
            csrTypes::csrMhpmcounter3: oldValue = loadMissCount;
            csrTypes::csrMhpmcounter4: oldValue = storeMissCount;
            csrTypes::csrMhpmcounter5: oldValue = branchMissCount;
            default: oldValue = '0;
        endcase
    end

    always_comb begin
        case (action.csrOp)
            csrTypes::csrOpWrite: newValue = action.writeData;
            csrTypes::csrOpSet: newValue = oldValue | action.writeData;
            csrTypes::csrOpClear: newValue = oldValue & ~action.writeData;
            default: newValue = oldValue;
        endcase
    end

    // Set or clear with an empty mask is a plain read
    assign doWrite = action.kind == pipeTypes::actCsrAccess
                     && (action.csrOp == csrTypes::csrOpWrite || action.writeData != '0);

    always_comb begin
        csrNext = csrView;
        csrNext.mcycle = csrView.mcycle + 1'b1;
        csrNext.minstret = csrView.minstret + action.retireCount;

        case (action.kind)
            pipeTypes::actTrap: begin
                csrNext.mstatus.mpie = csrView.mstatus.mie;
                csrNext.mstatus.mie = 1'b0;
                csrNext.mepc = action.trapPc;
                csrNext.mtval = action.trapAddr;  // Faulting address, if any
                csrNext.mcause.isInterrupt = 1'b0;
                csrNext.mcause.code = pipeTypes::causeCode(action.trap);
            end
            pipeTypes::actInterrupt: begin
                csrNext.mstatus.mpie = csrView.mstatus.mie;
                csrNext.mstatus.mie = 1'b0;
                csrNext.mepc = action.trapPc;   // Dropped slot resumes here
                csrNext.mtval = action.trapPc;
                csrNext.mcause.isInterrupt = 1'b1;
                csrNext.mcause.code = action.irqCode;
            end
            pipeTypes::actMret: begin
                csrNext.mstatus.mie = csrView.mstatus.mpie;
            end
            default: begin
                if (doWrite) begin
                    case (action.csrNum)  // mip and event counters are read only
                        csrTypes::csrMstatus: csrNext.mstatus = newValue;
                        csrTypes::csrMie: csrNext.mie = newValue;
                        csrTypes::csrMtvec: csrNext.mtvec = newValue;
                        csrTypes::csrMscratch: csrNext.mscratch = newValue;
                        csrTypes::csrMepc: csrNext.mepc = newValue;
                        csrTypes::csrMcause: csrNext.mcause = newValue;
                        csrTypes::csrMtval: csrNext.mtval = newValue;
                        csrTypes::csrMcycle: csrNext.mcycle = newValue;
                        csrTypes::csrMinstret: csrNext.minstret = newValue;
                        default: ;
                    endcase
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            csrReg <= '0;
        end else begin
            csrReg <= csrNext;
        end
    end

    assign readData = (action.kind == pipeTypes::actCsrAccess) ? oldValue : '0;

    assign redirect.valid = action.kind inside
                            {pipeTypes::actTrap, pipeTypes::actMret, pipeTypes::actInterrupt};
    assign redirect.target = (action.kind == pipeTypes::actMret) ?
                             csrView.mepc : {csrView.mtvec.base, csrTypes::mtvecAlign};

    assign csrState = csrView;

    // Commit stage only classifies real exceptions as traps
    trapCauseValid: assert property (
        @(posedge clk) disable iff (reset)
        action.kind == pipeTypes::actTrap |->
            !(action.trap inside {pipeTypes::causeNone, pipeTypes::causeMret})
    ) else $error("Trap action without a valid exception cause");

    // Trap and interrupt entry leave interrupts globally disabled afterwards
    entryClearsMie: assert property (
        @(posedge clk) disable iff (reset)
        redirect.valid && action.kind != pipeTypes::actMret |=> !csrState.mstatus.mie
    ) else $error("mstatus.MIE still set after trap or interrupt entry");

endmodule

// File: source/csrSubsystem.sv
/*
 * Top level of the machine-mode CSR subsystem. Connects the commit
 * stage, interrupt control, event counters and the CSR stage.
 */
`timescale 1ns/1ps

module csrSubsystem (
    input logic clk,
    input logic reset,
    input pipeTypes::CommitSlot slot,
    input pipeTypes::PerfEvents events,
    input logic timerIrq,
    input logic extIrq,
    output logic [csrTypes::dataWidth-1:0] readData,
    output pipeTypes::Redirect redirect,
    output csrTypes::CsrFile csrState
);

    pipeTypes::CsrAction action;
    pipeTypes::IrqCode irqCode;
    csrTypes::Mip mipBits;
    logic irqPending;
    logic [csrTypes::dataWidth-1:0] loadMissCount;
    logic [csrTypes::dataWidth-1:0] storeMissCount;
    logic [csrTypes::dataWidth-1:0] branchMissCount;

    commitStage commit (
        .clk(clk),
        .reset(reset),
        .slot(slot),
        .irqPending(irqPending),
        .irqCode(irqCode),
        .action(action)
    );

    interruptControl irqCtrl (
        .clk(clk),
        .reset(reset),
        .timerIrq(timerIrq),
        .extIrq(extIrq),
        .mstatusMie(csrState.mstatus.mie),
        .mieBits(csrState.mie),
        .mipBits(mipBits),
        .irqPending(irqPending),
        .irqCode(irqCode)
    );

    perfCounters counters (
        .clk(clk),
        .reset(reset),
        .events(events),
        .loadMissCount(loadMissCount),
        .storeMissCount(storeMissCount),
        .branchMissCount(branchMissCount)
    );

    csrUnit csr (
        .clk(clk),
        .reset(reset),
        .action(action),
        .mipBits(mipBits),
        .loadMissCount(loadMissCount),
        .storeMissCount(storeMissCount),
        .branchMissCount(branchMissCount),
        .readData(readData),
        .redirect(redirect),
        .csrState(csrState)
    );

endmodule

// File: bench/csrBench.sv
/*
 * Testbench for the CSR subsystem. Replays the vectors of the testdata file
 * one per cycle, then runs random write, set and clear rounds on mscratch.
 * Run from the project root so that the vector file is found.
 */
`timescale 1ns/1ps

module csrBench;

    localparam int redirectTimeout = 20;  // Cycles
    localparam int randomRounds = 8;

    logic clk;
    logic reset;
    pipeTypes::CommitSlot slot;
    pipeTypes::PerfEvents events;
    logic timerIrq;
    logic extIrq;
    logic [csrTypes::dataWidth-1:0] readData;
    pipeTypes::Redirect redirect;
    csrTypes::CsrFile csrState;

    integer seed;
    int checkCount;
    int mismatchCount;
    int otherErrors;

    // Result due one cycle after the last driven vector
    logic pendValid;
    logic pendCheckRd;
    logic [191:0] pendName;
    logic [31:0] pendRd;
    logic pendRv;
    logic [31:0] pendTgt;

    csrSubsystem uut (
        .clk(clk),
        .reset(reset),
        .slot(slot),
        .events(events),
        .timerIrq(timerIrq),
        .extIrq(extIrq),
        .readData(readData),
        .redirect(redirect),
        .csrState(csrState)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic compareValue(input logic [191:0] testName, input logic [31:0] expected,
                                input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            mismatchCount++;
            $display("mismatch %0s: expected %08h, actual %08h", testName, expected, actual);
        end
    endtask

    task automatic driveInputs(input logic [31:0] op, num, data, trap, pc, addr, ret, ev,
                               tirq, eirq);
        slot.csrOp = csrTypes::CsrOp'(op[1:0]);
        slot.csrNum = num[11:0];
        slot.writeData = data;
        slot.trap = pipeTypes::TrapCause'(trap[3:0]);
        slot.trapPc = pc;
        slot.trapAddr = addr;
        slot.retireCount = ret[1:0];
        events = pipeTypes::PerfEvents'(ev[2:0]);  // Load, store, branch from bit 2 down
        timerIrq = tirq[0];
        extIrq = eirq[0];
    endtask

    task automatic checkPrevious;
        if (pendValid) begin
            if (pendCheckRd) begin
                compareValue(pendName, pendRd, readData);
            end
            compareValue(pendName, {31'd0, pendRv}, {31'd0, redirect.valid});
            if (pendRv) begin
                compareValue(pendName, pendTgt, redirect.target);
            end
            pendValid = 1'b0;
        end
    endtask

    // One vector per falling edge, its result is checked at the next one
    task automatic stepVector(input logic [191:0] testName, input logic storeExpect,
                              input logic checkRd, input logic [31:0] op, num, data, trap,
                              pc, addr, ret, ev, tirq, eirq, expRd, input logic expRv,
                              input logic [31:0] expTgt);
        @(negedge clk);
        checkPrevious();
        driveInputs(op, num, data, trap, pc, addr, ret, ev, tirq, eirq);
        pendName = testName;
        pendCheckRd = checkRd;
        pendRd = expRd;
        pendRv = expRv;
        pendTgt = expTgt;
        pendValid = storeExpect;
    endtask

    // Inputs stay as driven while the interrupt works its way through
    task automatic waitForRedirect(input logic [191:0] testName, input logic [31:0] expTgt);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!redirect.valid && cycles < redirectTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (redirect.valid) begin
            compareValue(testName, expTgt, redirect.target);
        end else begin
            otherErrors++;
            $display("Timeout in %0s, no redirect after %0d cycles", testName, cycles);
        end
    endtask

    task automatic replayVectors;
        int fd;
        int fields;
        string lineText;
        logic [191:0] name;
        logic [31:0] mode, op, num, data, trap, pc, addr, ret, ev, tirq, eirq;
        logic [31:0] expRd, expRv, expTgt;
        fd = $fopen("bench/csrTestdata.txt", "r");
        if (fd == 0) begin
            otherErrors++;
            $display("Cannot open the vector file bench/csrTestdata.txt");
            return;
        end
        while (!$feof(fd)) begin
            if ($fgets(lineText, fd) == 0) break;
            if (lineText.len() < 2 || lineText.getc(0) == "#") continue;  // Blank or comment
            fields = $sscanf(lineText, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             name, mode, op, num, data, trap, pc, addr, ret, ev, tirq, eirq,
                             expRd, expRv, expTgt);
            if (fields != 15) begin
                otherErrors++;
                $display("Malformed vector line: %s", lineText);
                continue;
            end
            stepVector(name, mode == 0, 1'b1, op, num, data, trap, pc, addr, ret, ev, tirq,
                       eirq, expRd, expRv[0], expTgt);
            if (mode != 0) begin
                waitForRedirect(name, expTgt);
            end
        end
        $fclose(fd);
    endtask

    task automatic accessScratch(input logic [191:0] testName, input logic checkRd,
                                 input logic [31:0] op, input logic [31:0] data,
                                 input logic [31:0] expRd);
        stepVector(testName, 1'b1, checkRd, op, {20'd0, csrTypes::csrMscratch}, data,
                   32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0, expRd, 1'b0, 32'd0);
    endtask

    task automatic runRandomScratch;
        logic [31:0] wrVal;
        logic [31:0] setVal;
        logic [31:0] clrVal;
        logic [31:0] model;
        model = '0;
        for (int i = 0; i < randomRounds; i++) begin
            wrVal = $random(seed);
            setVal = $random(seed);
            clrVal = $random(seed);
            accessScratch("rndWrite", i > 0, 32'd1, wrVal, model);  // Round 0 follows the file
            accessScratch("rndSet", 1'b1, 32'd2, setVal, wrVal);
            accessScratch("rndClear", 1'b1, 32'd3, clrVal, wrVal | setVal);
            model = (wrVal | setVal) & ~clrVal;
            accessScratch("rndRead", 1'b1, 32'd2, 32'd0, model);
            // Clear still in its CSR stage cycle, the register holds the set result
            compareValue("rndState", wrVal | setVal, csrState.mscratch);
        end
    endtask

    initial begin
        seed = 32'h95b4;
        checkCount = 0;
        mismatchCount = 0;
        otherErrors = 0;
        pendValid = 1'b0;
        pendCheckRd = 1'b0;
        pendName = '0;
        pendRd = '0;
        pendRv = 1'b0;
        pendTgt = '0;
        reset = 1'b1;
        slot = '0;
        events = '0;
        timerIrq = 1'b0;
        extIrq = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        replayVectors();
        runRandomScratch();
        @(negedge clk);
        checkPrevious();

        $display("Checks %0d, mismatches %0d, other errors %0d",
                 checkCount, mismatchCount, otherErrors);
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: bench/csrTestdata.txt
# name mode csrOp csrNum writeData trap trapPc trapAddr retire events timerIrq extIrq
# expReadData expRedirectValid expTarget, all hex; mode 1 waits for the redirect
wrScratch  0 1 340 a5a5f00f 0 00000000 00000000 1 0 0 0 00000000 0 00000000
setScratch 0 2 340 0000ff00 0 00000000 00000000 0 0 0 0 a5a5f00f 0 00000000
clrScratch 0 3 340 a0000000 0 00000000 00000000 1 0 0 0 a5a5ff0f 0 00000000
rdScratch  0 2 340 00000000 0 00000000 00000000 0 0 0 0 05a5ff0f 0 00000000
wrMtvec    0 1 305 00003000 0 00000000 00000000 2 0 0 0 00000000 0 00000000
setMtvec   0 2 305 00000400 0 00000000 00000000 0 0 0 0 00003000 0 00000000
clrMtvec   0 3 305 00001000 0 00000000 00000000 0 0 0 0 00003400 0 00000000
rdMtvec    0 2 305 00000000 0 00000000 00000000 0 0 0 0 00002400 0 00000000
wrMstatus  0 1 300 00000008 0 00000000 00000000 0 0 0 0 00000000 0 00000000
ecall      0 0 000 00000000 1 00000480 00000000 0 0 0 0 00000000 1 00002400
rdMepc     0 2 341 00000000 0 00000000 00000000 0 0 0 0 00000480 0 00000000
rdMcause   0 2 342 00000000 0 00000000 00000000 0 0 0 0 0000000b 0 00000000
rdMstatus  0 2 300 00000000 0 00000000 00000000 0 0 0 0 00000080 0 00000000
mret       0 0 000 00000000 3 00000000 00000000 0 0 0 0 00000000 1 00000480
rdMstatus2 0 2 300 00000000 0 00000000 00000000 0 0 0 0 00000088 0 00000000
wrMie      0 1 304 00000080 0 00000000 00000000 0 0 0 0 00000000 0 00000000
timerEntry 1 0 000 00000000 0 00000600 00000000 0 0 1 0 00000000 1 00002400
rdMcause2  0 2 342 00000000 0 00000000 00000000 0 0 1 0 80000007 0 00000000
rdMepc2    0 2 341 00000000 0 00000000 00000000 0 0 1 0 00000600 0 00000000
rdMtval    0 2 343 00000000 0 00000000 00000000 0 0 1 0 00000600 0 00000000
rdMip      0 2 344 00000000 0 00000000 00000000 0 0 1 0 00000080 0 00000000
noIrq1     0 0 000 00000000 0 00000000 00000000 0 0 1 0 00000000 0 00000000
noIrq2     0 0 000 00000000 0 00000000 00000000 0 0 1 0 00000000 0 00000000
rdMstatus3 0 2 300 00000000 0 00000000 00000000 0 0 1 0 00000080 0 00000000
timerOff   0 0 000 00000000 0 00000000 00000000 0 0 0 0 00000000 0 00000000
rdInstret1 0 2 b02 00000000 0 00000000 00000000 0 0 0 0 00000004 0 00000000
events1    0 0 000 00000000 0 00000000 00000000 3 7 0 0 00000000 0 00000000
events2    0 0 000 00000000 0 00000000 00000000 2 4 0 0 00000000 0 00000000
events3    0 0 000 00000000 0 00000000 00000000 1 5 0 0 00000000 0 00000000
rdHpm3     0 2 b03 00000000 0 00000000 00000000 0 0 0 0 00000003 0 00000000
rdHpm4     0 2 b04 00000000 0 00000000 00000000 0 0 0 0 00000001 0 00000000
rdHpm5     0 2 b05 00000000 0 00000000 00000000 0 0 0 0 00000002 0 00000000
rdInstret2 0 2 b02 00000000 0 00000000 00000000 0 0 0 0 0000000a 0 00000000

// File: list.f
common/csrTypes.sv
common/pipeTypes.sv
source/commitStage.sv
source/interruptControl.sv
csrUnit/perfCounters.sv
csrUnit/csrUnit.sv
source/csrSubsystem.sv
bench/csrBench.sv

// File: run.sh
#!/bin/bash
# Build the testbench with Verilator, run it and look for the pass message in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module csrBench -f list.f -o csrSim \
    && ./obj_dir/csrSim | tee sim.log \
    || { echo "Build or simulation run failed"; exit 1; }
grep -qx "Test OK" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
